// File: hdl/axis_reader_pkg.sv
package axis_reader_pkg;

  // Datapath widths
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 16;

  // Stream FIFO geometry
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_W      = 4;   // Index into FIFO_DEPTH entries
  localparam int LEVEL_W    = 5;   // Holds 0 to FIFO_DEPTH

  // Register map, byte offsets
  localparam logic [ADDR_W-1:0] OFS_DATA  = 16'h0000;  // Pops one stream word
  localparam logic [ADDR_W-1:0] OFS_LEVEL = 16'h0004;  // FIFO fill level

  // Decoded read operation
  typedef enum logic [1:0] {
    RD_DATA  = 2'd0,
    RD_LEVEL = 2'd1,
    RD_BAD   = 2'd2
  } rd_kind_e;

  // AXI response code
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  // Read request as carried through the pipeline
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  // Read response, unpacked onto the R channel at the end
  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } rd_rsp_t;

endpackage

// File: hdl/input_buffer.sv
`timescale 1ns/10ps

module input_buffer
  import axis_reader_pkg::*;
(
  input  logic    aclk,
  input  logic    arst_n,
  input  logic    in_valid,
  output logic    in_ready,
  input  rd_req_t in_req,
  output logic    out_valid,
  input  logic    out_ready,
  output rd_req_t out_req
);

  logic    live;   // Low only in the first cycle after reset
  logic    full;
  logic    load;
  rd_req_t entry;

  // Take a new request when empty or when the held one leaves now
  assign in_ready  = live & (~full | out_ready);
  assign load      = in_valid & in_ready;
  assign out_valid = full;
  assign out_req   = entry;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      live <= 1'b0;
      full <= 1'b0;
    end else begin
      live <= 1'b1;
      full <= load | (full & ~out_ready);
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      entry <= in_req;
    end
  end

  // Downstream sees a steady request for as long as it stalls
  req_stable_a: assert property (
    @(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> $stable(out_req)
  ) else $error("input_buffer: out_req changed under stall");

endmodule

// File: hdl/output_buffer.sv
`timescale 1ns/10ps

module output_buffer
  import axis_reader_pkg::*;
(
  input  logic    aclk,
  input  logic    arst_n,
  input  logic    in_valid,
  output logic    in_ready,
  input  rd_rsp_t in_rsp,
  output logic    out_valid,
  input  logic    out_ready,
  output rd_rsp_t out_rsp
);

  logic    live;   // Holds ready low for one cycle out of reset
  logic    full;
  logic    load;
  rd_rsp_t entry;

  // Free slot, or the R beat completes on this edge
  assign in_ready  = live & (~full | out_ready);
  assign load      = in_valid & in_ready;
  assign out_valid = full;
  assign out_rsp   = entry;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      live <= 1'b0;
      full <= 1'b0;
    end else begin
      live <= 1'b1;
      full <= load | (full & ~out_ready);
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      entry <= in_rsp;
    end
  end

  // R channel rules: rvalid and its payload hold until rready
  rsp_stable_a: assert property (
    @(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_rsp)
  ) else $error("output_buffer: response changed before rready");

  // Every response leaves with a legal AXI code
  rsp_code_a: assert property (
    @(posedge aclk) disable iff (!arst_n)
    out_valid |-> out_rsp.resp inside {RESP_OKAY, RESP_SLVERR}
  ) else $error("output_buffer: unexpected response code");

endmodule

// File: hdl/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo
  import axis_reader_pkg::*;
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic [DATA_W-1:0]  s_axis_tdata,
  input  logic               s_axis_tvalid,
  output logic               s_axis_tready,
  input  logic               pop,
  output logic [DATA_W-1:0]  head_data,
  output logic               head_valid,
  output logic [LEVEL_W-1:0] level
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [LEVEL_W-1:0] count;
  logic               live;
  logic               push;

  assign s_axis_tready = live & (count != LEVEL_W'(FIFO_DEPTH));  // Low when full
  assign push          = s_axis_tvalid & s_axis_tready;

  assign head_data  = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign level      = count;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      live   <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      live <= 1'b1;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_axis_tdata;
    end
  end

  level_max_a: assert property (
    @(posedge aclk) disable iff (!arst_n)
    level <= LEVEL_W'(FIFO_DEPTH)
  ) else $error("stream_fifo: level above FIFO_DEPTH");

endmodule

// File: hdl/axi_axis_reader.sv
`timescale 1ns/10ps

module axi_axis_reader
  import axis_reader_pkg::*;
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic               req_valid,
  output logic               req_ready,
  input  rd_req_t            req,
  output logic               rsp_valid,
  input  logic               rsp_ready,
  output rd_rsp_t            rsp,
  input  logic [DATA_W-1:0]  head_data,
  input  logic               head_valid,
  input  logic [LEVEL_W-1:0] level,
  output logic               pop
);

  rd_kind_e kind;
  logic     xfer;

  // Offset decode
  always_comb begin
    case (req.addr)
      OFS_DATA:  kind = RD_DATA;
      OFS_LEVEL: kind = RD_LEVEL;
      default:   kind = RD_BAD;
    endcase
  end

  // Request and response move together, so stall passes straight back
  assign rsp_valid = req_valid;
  assign req_ready = rsp_ready;
  assign xfer      = req_valid & rsp_ready;

  // An empty FIFO yields zero and is left untouched
  assign pop = xfer & (kind == RD_DATA) & head_valid;

  always_comb begin
    rsp.data = '0;
    rsp.resp = RESP_OKAY;
    case (kind)
      RD_DATA: begin
        if (head_valid) begin
          rsp.data = head_data;
        end
      end
      RD_LEVEL: rsp.data = {{(DATA_W-LEVEL_W){1'b0}}, level};
      default:  rsp.resp = RESP_SLVERR;
    endcase
  end

  pop_nonempty_a: assert property (
    @(posedge aclk) disable iff (!arst_n)
    pop |-> head_valid
  ) else $error("axi_axis_reader: pop from empty FIFO");

endmodule

// File: hdl/axis_reader_top.sv
`timescale 1ns/10ps

module axis_reader_top
  import axis_reader_pkg::*;
(
  input  logic              aclk,
  input  logic              arst_n,
  // AXI-Stream input
  input  logic [DATA_W-1:0] s_axis_tdata,
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  // AXI4-Lite read channels
  input  logic [ADDR_W-1:0] s_axi_araddr,
  input  logic              s_axi_arvalid,
  output logic              s_axi_arready,
  output logic [DATA_W-1:0] s_axi_rdata,
  output resp_e             s_axi_rresp,
  output logic              s_axi_rvalid,
  input  logic              s_axi_rready
);

  rd_req_t            ar_req;
  rd_req_t            req;
  logic               req_valid;
  logic               req_ready;
  rd_rsp_t            rsp;
  logic               rsp_valid;
  logic               rsp_ready;
  rd_rsp_t            r_rsp;
  logic               pop;
  logic [DATA_W-1:0]  head_data;
  logic               head_valid;
  logic [LEVEL_W-1:0] level;

  assign ar_req.addr = s_axi_araddr;
  assign s_axi_rdata = r_rsp.data;
  assign s_axi_rresp = r_rsp.resp;

  stream_fifo u_stream_fifo (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .pop           (pop),
    .head_data     (head_data),
    .head_valid    (head_valid),
    .level         (level)
  );

  input_buffer u_input_buffer (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (s_axi_arvalid),
    .in_ready  (s_axi_arready),
    .in_req    (ar_req),
    .out_valid (req_valid),
    .out_ready (req_ready),
    .out_req   (req)
  );

  axi_axis_reader u_axi_axis_reader (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .head_data  (head_data),
    .head_valid (head_valid),
    .level      (level),
    .pop        (pop)
  );

  output_buffer u_output_buffer (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (rsp_valid),
    .in_ready  (rsp_ready),
    .in_rsp    (rsp),
    .out_valid (s_axi_rvalid),
    .out_ready (s_axi_rready),
    .out_rsp   (r_rsp)
  );

endmodule

// File: sim/axis_reader_tb.sv
`timescale 1ns/10ps

module axis_reader_tb
  import axis_reader_pkg::*;
();

  localparam int          TIMEOUT = 100;  // Cycles allowed for any single wait
  localparam int unsigned SEED    = 32'h4920_c8d9;
  localparam string       TRACE   = "sim/axis_reader_trace.txt";

  logic              aclk;
  logic              arst_n;
  logic [DATA_W-1:0] s_axis_tdata;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  logic [ADDR_W-1:0] s_axi_araddr;
  logic              s_axi_arvalid;
  logic              s_axi_arready;
  logic [DATA_W-1:0] s_axi_rdata;
  resp_e             s_axi_rresp;
  logic              s_axi_rvalid;
  logic              s_axi_rready;

  logic [DATA_W-1:0] push_q[$];       // Words waiting for the stream driver
  rd_rsp_t           exp_q[$];        // Responses still owed on R, oldest first
  rd_rsp_t           beat_exp;
  rd_rsp_t           exp_rsp;
  int                stall_left;      // Cycles of forced low rready still to run
  int                stream_blocked;
  int                r_idle;
  logic              took;
  int                fd;
  int                n;
  int                count;
  logic [63:0]       cmd;
  logic [8*128-1:0]  rest;
  logic [31:0]       arg_a;
  logic [31:0]       arg_b;
  logic [31:0]       arg_c;

  axis_reader_top u_axis_reader_top (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  always #2 aclk = ~aclk;

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    stop_run();
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input resp_e got, input resp_e exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  // Inputs change here, outputs are sampled on the falling edge
  task automatic next_drive_slot();
    @(posedge aclk);
    #0.5;
  endtask

  task automatic wait_reads_done();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == TIMEOUT) report_failure("timed out waiting for outstanding reads");
      waited++;
      next_drive_slot();
    end
  endtask

  // Stream is idle, or parked on a full FIFO
  task automatic wait_stream_settled();
    int waited;
    waited = 0;
    @(negedge aclk);
    while (!((push_q.size() == 0 && !s_axis_tvalid) || (s_axis_tvalid && !s_axis_tready))) begin
      if (waited == TIMEOUT) report_failure("timed out waiting for the stream to settle");
      waited++;
      @(negedge aclk);
    end
    next_drive_slot();
  endtask

  task automatic push_words(input logic [DATA_W-1:0] first, input int words);
    int i;
    wait_reads_done();  // Earlier reads must see the FIFO without these words
    @(negedge aclk);
    for (i = 0; i < words; i++) begin
      push_q.push_back(first + DATA_W'(i));
    end
    next_drive_slot();
  endtask

  task automatic issue_read(input logic [ADDR_W-1:0] ofs, input rd_rsp_t exp);
    int waited;
    waited = 0;
    wait_stream_settled();
    s_axi_araddr  = ofs;
    s_axi_arvalid = 1'b1;
    @(negedge aclk);
    while (!s_axi_arready) begin
      if (waited == TIMEOUT) report_failure("timed out waiting for s_axi_arready");
      waited++;
      @(negedge aclk);
    end
    next_drive_slot();
    s_axi_arvalid = 1'b0;
    exp_q.push_back(exp);
  endtask

  task automatic start_stall(input int cycles);
    @(negedge aclk);
    stall_left = cycles;
    next_drive_slot();
  endtask

  // Stream source, one word at a time from push_q
  always begin
    @(negedge aclk);
    took = s_axis_tvalid && s_axis_tready;
    if (s_axis_tvalid && !took) begin
      stream_blocked++;
      if (stream_blocked > TIMEOUT) report_failure("timed out waiting for s_axis_tready");
    end else begin
      stream_blocked = 0;
    end
    next_drive_slot();
    if (took) s_axis_tvalid = 1'b0;
    if (!s_axis_tvalid && push_q.size() != 0) begin
      s_axis_tdata  = push_q.pop_front();
      s_axis_tvalid = 1'b1;
    end
  end

  // R ready pattern, seeded in the process that draws from it
  initial begin
    void'($urandom(SEED));
    forever begin
      next_drive_slot();
      if (stall_left > 0) begin
        s_axi_rready = 1'b0;
        stall_left--;
      end else begin
        s_axi_rready = ($urandom % 4) != 0;  // Ready about three cycles in four
      end
    end
  end

  // R channel monitor, checks each beat against the oldest owed response
  always begin
    @(negedge aclk);
    if (s_axi_rvalid && s_axi_rready) begin
      if (exp_q.size() == 0) report_failure("R beat arrived with no read outstanding");
      beat_exp = exp_q.pop_front();
      check_data("s_axi_rdata", s_axi_rdata, beat_exp.data);
      check_resp("s_axi_rresp", s_axi_rresp, beat_exp.resp);
      r_idle = 0;
    end else if (exp_q.size() != 0) begin
      r_idle++;
      if (r_idle > TIMEOUT) report_failure("timed out waiting for s_axi_rvalid");
    end else begin
      r_idle = 0;
    end
  end

  initial begin
    aclk           = 1'b0;
    arst_n         = 1'b0;
    s_axis_tdata   = '0;
    s_axis_tvalid  = 1'b0;
    s_axi_araddr   = '0;
    s_axi_arvalid  = 1'b0;
    s_axi_rready   = 1'b0;
    stall_left     = 0;
    stream_blocked = 0;
    r_idle         = 0;
    fd = $fopen(TRACE, "r");
    if (fd == 0) report_failure("cannot open the trace file");
    repeat (2) @(posedge aclk);
    #0.5;
    arst_n = 1'b1;
    while ($fscanf(fd, "%s", cmd) == 1) begin
      if (cmd == "#") begin
        n = $fgets(rest, fd);  // Comment line
      end else if (cmd == "PUSH") begin
        n = $fscanf(fd, "%h %d", arg_a, count);
        if (n != 2) report_failure("malformed PUSH line in the trace");
        push_words(arg_a, count);
      end else if (cmd == "READ") begin
        n = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
        if (n != 3) report_failure("malformed READ line in the trace");
        exp_rsp.data = arg_b;
        exp_rsp.resp = resp_e'(arg_c[1:0]);
        issue_read(arg_a[ADDR_W-1:0], exp_rsp);
      end else if (cmd == "STALL") begin
        n = $fscanf(fd, "%d", count);
        if (n != 1) report_failure("malformed STALL line in the trace");
        start_stall(count);
      end else begin
        report_failure("unknown command in the trace");
      end
    end
    $fclose(fd);
    wait_reads_done();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: sim/axis_reader_trace.txt
# PUSH data count | READ offset exp_data exp_resp | STALL cycles
# count words go in as data, data+1, ... and exp_resp is 0 for OKAY, 2 for SLVERR
PUSH 0000a001 1
PUSH 0000a002 1
PUSH 0000a003 1
READ 0004 00000003 0
READ 0000 0000a001 0
READ 0004 00000002 0
READ 0000 0000a002 0
READ 0000 0000a003 0
READ 0000 00000000 0
READ 0004 00000000 0
READ 0008 00000000 2
PUSH 5a5a0001 1
READ 000c 00000000 2
READ 0004 00000001 0
READ 0000 5a5a0001 0
PUSH 0000b001 3
STALL 12
READ 0000 0000b001 0
READ 0000 0000b002 0
READ 0000 0000b003 0
READ 0004 00000000 0
PUSH 0000c000 16
READ 0004 00000010 0
PUSH 0000c010 1
READ 0000 0000c000 0
READ 0004 00000010 0
READ 0000 0000c001 0
READ 0000 0000c002 0
READ 0004 0000000e 0

// File: all.f
hdl/axis_reader_pkg.sv
hdl/input_buffer.sv
hdl/output_buffer.sv
hdl/stream_fifo.sv
hdl/axi_axis_reader.sv
hdl/axis_reader_top.sv
sim/axis_reader_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module axis_reader_tb -f all.f -o axis_reader_sim
./obj_dir/axis_reader_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
